/* source/wired_fcc_pkg.sv */
`default_nettype none

package wired_fcc_pkg;

    // operand and datapath widths
    localparam int fp_width  = 32;
    localparam int exp_width = 8;
    localparam int man_width = 23;
    localparam int xlen      = 32;

    // branch offset immediate, sign-extended to xlen
    localparam int imm_width = 23;

    // writeback tag
    localparam int wid_width = 5;

    // fcmp condition mask
    localparam int cond_width = 5;

    // signal on quiet NaN, no relation of its own
    localparam int cond_sig_bit = 0;
    localparam int cond_lt_bit  = 1;
    localparam int cond_eq_bit  = 2;
    localparam int cond_un_bit  = 3;
    // ordered and not equal
    localparam int cond_ne_bit  = 4;

    // fclass.s result bits
    localparam int cls_snan = 0;
    localparam int cls_qnan = 1;

    // negative group
    localparam int cls_neg_inf  = 2;
    localparam int cls_neg_norm = 3;
    localparam int cls_neg_sub  = 4;
    localparam int cls_neg_zero = 5;

    // positive group
    localparam int cls_pos_inf  = 6;
    localparam int cls_pos_norm = 7;
    localparam int cls_pos_sub  = 8;
    localparam int cls_pos_zero = 9;

    // sanity on field split of a single-precision word
    localparam int sign_pos = fp_width - 1;
    localparam int exp_lsb  = man_width;

    // top mantissa bit tells quiet from signalling NaN
    localparam int quiet_bit = man_width - 1;

endpackage

`default_nettype wire

/* source/fp32_classifier.sv */
`default_nettype none

module fp32_classifier (
    input  wire  [wired_fcc_pkg::fp_width-1:0] operand_i,
    output logic                               is_normal_o,
    output logic                               is_subnormal_o,
    output logic                               is_zero_o,
    output logic                               is_inf_o,
    output logic                               is_nan_o,
    output logic                               is_signalling_o,
    output logic                               is_quiet_o
);

    import wired_fcc_pkg::*;

    logic [exp_width-1:0] exponent;
    logic [man_width-1:0] mantissa;
    logic                 exp_ones;
    logic                 exp_zero;
    logic                 man_zero;

    // split the encoding, sign is not needed here
    assign exponent = operand_i[exp_lsb +: exp_width];
    assign mantissa = operand_i[man_width-1:0];

    assign exp_ones = &exponent;
    assign exp_zero = ~|exponent;
    assign man_zero = ~|mantissa;

    // finite classes
    assign is_normal_o    = !exp_ones && !exp_zero;
    assign is_subnormal_o = exp_zero && !man_zero;
    assign is_zero_o      = exp_zero && man_zero;

    // all-ones exponent
    assign is_inf_o = exp_ones && man_zero;
    assign is_nan_o = exp_ones && !man_zero;

    // quiet NaN has the top mantissa bit set
    assign is_signalling_o = is_nan_o && !mantissa[quiet_bit];
    assign is_quiet_o      = is_nan_o && mantissa[quiet_bit];

endmodule

`default_nettype wire

/* source/fp32_compare.sv */
`default_nettype none

module fp32_compare (
    input  wire  [wired_fcc_pkg::fp_width-1:0] opa_i,
    input  wire  [wired_fcc_pkg::fp_width-1:0] opb_i,
    input  wire                                a_is_nan_i,
    input  wire                                b_is_nan_i,
    input  wire                                a_is_zero_i,
    input  wire                                b_is_zero_i,
    output logic                               un_o,
    output logic                               eq_o,
    output logic                               lt_o,
    output logic                               ne_o
);

    import wired_fcc_pkg::*;

    logic any_nan;
    logic both_zero;
    logic same_bits;
    logic any_sign;
    logic raw_lt;
    logic ordered;

    assign any_nan   = a_is_nan_i || b_is_nan_i;
    assign both_zero = a_is_zero_i && b_is_zero_i;
    assign same_bits = (opa_i == opb_i);

    // either sign set flips the magnitude order
    assign any_sign = opa_i[sign_pos] || opb_i[sign_pos];

    // unsigned compare of sign-magnitude words
    assign raw_lt = (opa_i < opb_i);

    /*
     * Equal covers +0 == -0. Once equal is excluded, the unsigned
     * compare of the raw words gives the right order for two
     * positives; with a negative operand involved it comes out
     * reversed, so it is inverted.
     */
    assign un_o    = any_nan;
    assign ordered = !any_nan;
    assign eq_o    = ordered && (same_bits || both_zero);
    assign lt_o    = ordered && !eq_o && (raw_lt ^ any_sign);
    assign ne_o    = ordered && !eq_o;

endmodule

`default_nettype wire

/* source/fcc_exec.sv */
`default_nettype none

module fcc_exec (
    input  wire                                  clk,
    input  wire                                  rst_n_i,
    input  wire                                  flush_i,
    input  wire                                  fcc_commit_i,
    // request
    input  wire                                  req_valid_i,
    output logic                                 req_ready_o,
    input  wire                                  op_fcmp_i,
    input  wire                                  op_movxr2cf_i,
    input  wire                                  op_movcf2xr_i,
    input  wire                                  op_bceqz_i,
    input  wire                                  op_bcnez_i,
    input  wire                                  op_fsel_i,
    input  wire                                  op_fclass_i,
    input  wire  [wired_fcc_pkg::cond_width-1:0] cond_i,
    input  wire  [wired_fcc_pkg::fp_width-1:0]   opa_i,
    input  wire  [wired_fcc_pkg::fp_width-1:0]   opb_i,
    input  wire  [wired_fcc_pkg::xlen-1:0]       pc_i,
    input  wire  [wired_fcc_pkg::imm_width-1:0]  offset_i,
    input  wire  [wired_fcc_pkg::wid_width-1:0]  wid_i,
    // response
    output logic                                 resp_valid_o,
    input  wire                                  resp_ready_i,
    output logic [wired_fcc_pkg::xlen-1:0]       result_o,
    output logic                                 fcc_o,
    output logic                                 need_jump_o,
    output logic [wired_fcc_pkg::xlen-1:0]       target_o,
    output logic                                 nv_o,
    output logic [wired_fcc_pkg::wid_width-1:0]  wid_o,
    // held operands to the classifiers
    output logic [wired_fcc_pkg::fp_width-1:0]   op_a_o,
    output logic [wired_fcc_pkg::fp_width-1:0]   op_b_o,
    // classifier of A
    input  wire                                  a_is_normal_i,
    input  wire                                  a_is_subnormal_i,
    input  wire                                  a_is_zero_i,
    input  wire                                  a_is_inf_i,
    input  wire                                  a_is_signalling_i,
    input  wire                                  a_is_quiet_i,
    // classifier of B
    input  wire                                  b_is_nan_i,
    input  wire                                  b_is_signalling_i,
    // comparator
    input  wire                                  cmp_un_i,
    input  wire                                  cmp_eq_i,
    input  wire                                  cmp_lt_i,
    input  wire                                  cmp_ne_i
);

    import wired_fcc_pkg::*;

    logic                  load_en;
    logic                  resp_leave;
    logic                  valid_q;
    logic                  fcmp_q;
    logic                  movxr2cf_q;
    logic                  bceqz_q;
    logic                  bcnez_q;
    logic                  fsel_q;
    logic                  fclass_q;
    logic [cond_width-1:0] cond_q;
    logic [fp_width-1:0]   op_a_q;
    logic [fp_width-1:0]   op_b_q;
    logic [xlen-1:0]       pc_q;
    logic [imm_width-1:0]  offset_q;
    logic [wid_width-1:0]  wid_q;
    logic                  fcc_q;
    logic                  fcc_next;
    logic [cond_width-1:0] rel_vec;
    logic                  any_signal;
    logic                  any_nan;

    // register takes a new request when empty or when the old one leaves
    assign req_ready_o = !valid_q || resp_ready_i;
    assign load_en     = req_ready_o;
    assign resp_leave  = valid_q && resp_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (load_en) begin
            valid_q <= req_valid_i;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load_en && req_valid_i) begin
            fcmp_q     <= op_fcmp_i;
            movxr2cf_q <= op_movxr2cf_i;
            bceqz_q    <= op_bceqz_i;
            bcnez_q    <= op_bcnez_i;
            fsel_q     <= op_fsel_i;
            fclass_q   <= op_fclass_i;
            cond_q     <= cond_i;
            op_a_q     <= opa_i;
            op_b_q     <= opb_i;
            pc_q       <= pc_i;
            offset_q   <= offset_i;
            wid_q      <= wid_i;
        end
    end

    // local fcc, committed when the response leaves
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fcc_q <= 1'b0;
        end else if (flush_i) begin
            fcc_q <= fcc_commit_i;
        end else if (resp_leave) begin
            fcc_q <= fcc_next;
        end
    end

    // relation vector lines up with the condition mask
    always_comb begin
        rel_vec               = '0;
        rel_vec[cond_lt_bit]  = cmp_lt_i;
        rel_vec[cond_eq_bit]  = cmp_eq_i;
        rel_vec[cond_un_bit]  = cmp_un_i;
        rel_vec[cond_ne_bit]  = cmp_ne_i;
    end

    // movxr2cf overrides fcmp
    always_comb begin
        fcc_next = fcc_q;
        if (fcmp_q) begin
            fcc_next = |(rel_vec & cond_q);
        end
        if (movxr2cf_q) begin
            fcc_next = op_a_q[0];
        end
    end

    assign any_signal = a_is_signalling_i || b_is_signalling_i;
    assign any_nan    = a_is_signalling_i || a_is_quiet_i || b_is_nan_i;

    always_comb begin
        result_o = '0;
        nv_o     = 1'b0;
        if (fsel_q) begin
            result_o = fcc_q ? op_b_q : op_a_q;
            nv_o     = any_signal;
        end else if (fclass_q) begin
            result_o[cls_snan] = a_is_signalling_i;
            result_o[cls_qnan] = a_is_quiet_i;
            nv_o               = a_is_signalling_i;
            if (op_a_q[sign_pos]) begin
                result_o[cls_neg_inf]  = a_is_inf_i;
                result_o[cls_neg_norm] = a_is_normal_i;
                result_o[cls_neg_sub]  = a_is_subnormal_i;
                result_o[cls_neg_zero] = a_is_zero_i;
            end else begin
                result_o[cls_pos_inf]  = a_is_inf_i;
                result_o[cls_pos_norm] = a_is_normal_i;
                result_o[cls_pos_sub]  = a_is_subnormal_i;
                result_o[cls_pos_zero] = a_is_zero_i;
            end
        end else begin
            // movcf2xr, fcmp, movxr2cf and branches report the old fcc
            result_o[0] = fcc_q;
        end
        if (fcmp_q) begin
            nv_o = any_signal || (any_nan && cond_q[cond_sig_bit]);
        end
    end

    assign need_jump_o  = (bceqz_q && !fcc_q) || (bcnez_q && fcc_q);
    assign target_o     = pc_q + {{(xlen-imm_width){offset_q[imm_width-1]}}, offset_q};
    assign fcc_o        = fcc_next;
    assign wid_o        = wid_q;
    assign resp_valid_o = valid_q;
    assign op_a_o       = op_a_q;
    assign op_b_o       = op_b_q;

endmodule

`default_nettype wire

/* source/wired_fcc_top.sv */
`default_nettype none

module wired_fcc_top (
    input  wire                                  clk,
    input  wire                                  rst_n_i,
    input  wire                                  flush_i,
    input  wire                                  fcc_commit_i,
    input  wire                                  req_valid_i,
    output logic                                 req_ready_o,
    input  wire                                  op_fcmp_i,
    input  wire                                  op_movxr2cf_i,
    input  wire                                  op_movcf2xr_i,
    input  wire                                  op_bceqz_i,
    input  wire                                  op_bcnez_i,
    input  wire                                  op_fsel_i,
    input  wire                                  op_fclass_i,
    input  wire  [wired_fcc_pkg::cond_width-1:0] cond_i,
    input  wire  [wired_fcc_pkg::fp_width-1:0]   opa_i,
    input  wire  [wired_fcc_pkg::fp_width-1:0]   opb_i,
    input  wire  [wired_fcc_pkg::xlen-1:0]       pc_i,
    input  wire  [wired_fcc_pkg::imm_width-1:0]  offset_i,
    input  wire  [wired_fcc_pkg::wid_width-1:0]  wid_i,
    output logic                                 resp_valid_o,
    input  wire                                  resp_ready_i,
    output logic [wired_fcc_pkg::xlen-1:0]       result_o,
    output logic                                 fcc_o,
    output logic                                 need_jump_o,
    output logic [wired_fcc_pkg::xlen-1:0]       target_o,
    output logic                                 nv_o,
    output logic [wired_fcc_pkg::wid_width-1:0]  wid_o
);

    import wired_fcc_pkg::*;

    logic [fp_width-1:0] op_a;
    logic [fp_width-1:0] op_b;

    // operand A class
    logic a_is_normal;
    logic a_is_subnormal;
    logic a_is_zero;
    logic a_is_inf;
    logic a_is_nan;
    logic a_is_signalling;
    logic a_is_quiet;

    // operand B, only what compare and NV need
    logic b_is_zero;
    logic b_is_nan;
    logic b_is_signalling;

    logic cmp_un;
    logic cmp_eq;
    logic cmp_lt;
    logic cmp_ne;

    fcc_exec u_exec (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .fcc_commit_i      (fcc_commit_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .op_fcmp_i         (op_fcmp_i),
        .op_movxr2cf_i     (op_movxr2cf_i),
        .op_movcf2xr_i     (op_movcf2xr_i),
        .op_bceqz_i        (op_bceqz_i),
        .op_bcnez_i        (op_bcnez_i),
        .op_fsel_i         (op_fsel_i),
        .op_fclass_i       (op_fclass_i),
        .cond_i            (cond_i),
        .opa_i             (opa_i),
        .opb_i             (opb_i),
        .pc_i              (pc_i),
        .offset_i          (offset_i),
        .wid_i             (wid_i),
        .resp_valid_o      (resp_valid_o),
        .resp_ready_i      (resp_ready_i),
        .result_o          (result_o),
        .fcc_o             (fcc_o),
        .need_jump_o       (need_jump_o),
        .target_o          (target_o),
        .nv_o              (nv_o),
        .wid_o             (wid_o),
        .op_a_o            (op_a),
        .op_b_o            (op_b),
        .a_is_normal_i     (a_is_normal),
        .a_is_subnormal_i  (a_is_subnormal),
        .a_is_zero_i       (a_is_zero),
        .a_is_inf_i        (a_is_inf),
        .a_is_signalling_i (a_is_signalling),
        .a_is_quiet_i      (a_is_quiet),
        .b_is_nan_i        (b_is_nan),
        .b_is_signalling_i (b_is_signalling),
        .cmp_un_i          (cmp_un),
        .cmp_eq_i          (cmp_eq),
        .cmp_lt_i          (cmp_lt),
        .cmp_ne_i          (cmp_ne)
    );

    fp32_classifier u_class_a (
        .operand_i       (op_a),
        .is_normal_o     (a_is_normal),
        .is_subnormal_o  (a_is_subnormal),
        .is_zero_o       (a_is_zero),
        .is_inf_o        (a_is_inf),
        .is_nan_o        (a_is_nan),
        .is_signalling_o (a_is_signalling),
        .is_quiet_o      (a_is_quiet)
    );

    fp32_classifier u_class_b (
        .operand_i       (op_b),
        .is_normal_o     (),
        .is_subnormal_o  (),
        .is_zero_o       (b_is_zero),
        .is_inf_o        (),
        .is_nan_o        (b_is_nan),
        .is_signalling_o (b_is_signalling),
        .is_quiet_o      ()
    );

    fp32_compare u_cmp (
        .opa_i       (op_a),
        .opb_i       (op_b),
        .a_is_nan_i  (a_is_nan),
        .b_is_nan_i  (b_is_nan),
        .a_is_zero_i (a_is_zero),
        .b_is_zero_i (b_is_zero),
        .un_o        (cmp_un),
        .eq_o        (cmp_eq),
        .lt_o        (cmp_lt),
        .ne_o        (cmp_ne)
    );

endmodule

`default_nettype wire

/* test/tb_wired_fcc.sv */
`default_nettype none

module tb_wired_fcc;
    timeunit 1ns;
    timeprecision 100ps;

    import wired_fcc_pkg::*;

    localparam int num_reqs    = 1500;
    localparam int cycle_limit = num_reqs * 2 + 1000;

    typedef struct packed {
        logic [xlen-1:0]      result;
        logic                 fcc;
        logic                 jump;
        logic [xlen-1:0]      target;
        logic                 nv;
        logic [wid_width-1:0] wid;
    } resp_t;

    logic                  clk;
    logic                  rst_n_i;
    logic                  flush_i;
    logic                  fcc_commit_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    logic                  op_fcmp_i;
    logic                  op_movxr2cf_i;
    logic                  op_movcf2xr_i;
    logic                  op_bceqz_i;
    logic                  op_bcnez_i;
    logic                  op_fsel_i;
    logic                  op_fclass_i;
    logic [cond_width-1:0] cond_i;
    logic [fp_width-1:0]   opa_i;
    logic [fp_width-1:0]   opb_i;
    logic [xlen-1:0]       pc_i;
    logic [imm_width-1:0]  offset_i;
    logic [wid_width-1:0]  wid_i;
    logic                  resp_valid_o;
    logic                  resp_ready_i;
    logic [xlen-1:0]       result_o;
    logic                  fcc_o;
    logic                  need_jump_o;
    logic [xlen-1:0]       target_o;
    logic                  nv_o;
    logic [wid_width-1:0]  wid_o;

    // reference model state
    resp_t exp_q[$];
    logic  model_fcc;
    logic  prev_req_fire;
    logic  prev_flush;
    logic  prev_hold;
    resp_t held;
    int    value_errors;
    int    proto_errors;
    int    cycles;

    wired_fcc_top i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .fcc_commit_i  (fcc_commit_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .op_fcmp_i     (op_fcmp_i),
        .op_movxr2cf_i (op_movxr2cf_i),
        .op_movcf2xr_i (op_movcf2xr_i),
        .op_bceqz_i    (op_bceqz_i),
        .op_bcnez_i    (op_bcnez_i),
        .op_fsel_i     (op_fsel_i),
        .op_fclass_i   (op_fclass_i),
        .cond_i        (cond_i),
        .opa_i         (opa_i),
        .opb_i         (opb_i),
        .pc_i          (pc_i),
        .offset_i      (offset_i),
        .wid_i         (wid_i),
        .resp_valid_o  (resp_valid_o),
        .resp_ready_i  (resp_ready_i),
        .result_o      (result_o),
        .fcc_o         (fcc_o),
        .need_jump_o   (need_jump_o),
        .target_o      (target_o),
        .nv_o          (nv_o),
        .wid_o         (wid_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic is_nan(input logic [fp_width-1:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
    endfunction

    function automatic logic is_snan(input logic [fp_width-1:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // one-hot class straight from the encoding
    function automatic logic [9:0] class_of(input logic [fp_width-1:0] x);
        logic [9:0]  c;
        logic [7:0]  e;
        logic [22:0] m;
        c = '0;
        e = x[30:23];
        m = x[22:0];
        if (e == 8'hff && m != 23'h0) begin
            c[m[22] ? cls_qnan : cls_snan] = 1'b1;
        end else if (e == 8'hff) begin
            c[x[31] ? cls_neg_inf : cls_pos_inf] = 1'b1;
        end else if (e == 8'h00 && m == 23'h0) begin
            c[x[31] ? cls_neg_zero : cls_pos_zero] = 1'b1;
        end else if (e == 8'h00) begin
            c[x[31] ? cls_neg_sub : cls_pos_sub] = 1'b1;
        end else begin
            c[x[31] ? cls_neg_norm : cls_pos_norm] = 1'b1;
        end
        return c;
    endfunction

    // relation vector laid out like the condition mask
    function automatic logic [cond_width-1:0] relation_of(input logic [fp_width-1:0] a,
                                                          input logic [fp_width-1:0] b);
        logic [cond_width-1:0] rel;
        logic signed [32:0]    ka;
        logic signed [32:0]    kb;
        rel = '0;
        ka  = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
        kb  = b[31] ? -$signed({2'b00, b[30:0]}) : $signed({2'b00, b[30:0]});
        if (is_nan(a) || is_nan(b)) begin
            rel[cond_un_bit] = 1'b1;
        end else if (ka == kb) begin
            // covers +0 against -0
            rel[cond_eq_bit] = 1'b1;
        end else begin
            rel[cond_ne_bit] = 1'b1;
            rel[cond_lt_bit] = (ka < kb);
        end
        return rel;
    endfunction

    function automatic resp_t predict_response();
        resp_t                 r;
        logic                  old;
        logic signed [xlen-1:0] soff;
        old      = model_fcc;
        soff     = $signed(offset_i);
        r        = '0;
        r.fcc    = old;
        r.result = {{(xlen-1){1'b0}}, old};
        r.jump   = (op_bceqz_i && !old) || (op_bcnez_i && old);
        r.target = pc_i + soff;
        r.wid    = wid_i;
        if (op_fsel_i) begin
            r.result = old ? opb_i : opa_i;
            r.nv     = is_snan(opa_i) || is_snan(opb_i);
        end else if (op_fclass_i) begin
            r.result = {22'h0, class_of(opa_i)};
            r.nv     = is_snan(opa_i);
        end
        if (op_fcmp_i) begin
            r.fcc = |(relation_of(opa_i, opb_i) & cond_i);
            r.nv  = is_snan(opa_i) || is_snan(opb_i) ||
                    ((is_nan(opa_i) || is_nan(opb_i)) && cond_i[cond_sig_bit]);
        end
        if (op_movxr2cf_i) begin
            r.fcc = opa_i[0];
        end
        model_fcc = r.fcc;
        return r;
    endfunction

    function automatic resp_t current_resp();
        return {result_o, fcc_o, need_jump_o, target_o, nv_o, wid_o};
    endfunction

    task automatic compare_field(input string name, input logic [xlen-1:0] exp_v,
                                 input logic [xlen-1:0] act_v);
        assert (exp_v === act_v) else begin
            value_errors++;
            $display("error: %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic compare_resp(input resp_t e, input resp_t g);
        compare_field("result_o", e.result, g.result);
        compare_field("fcc_o", e.fcc, g.fcc);
        compare_field("need_jump_o", e.jump, g.jump);
        compare_field("target_o", e.target, g.target);
        compare_field("nv_o", e.nv, g.nv);
        compare_field("wid_o", e.wid, g.wid);
    endtask

    // checks run mid-cycle, where every signal has settled
    always @(negedge clk) begin : check_resp
        resp_t got;
        logic  exp_valid;
        logic  exp_ready;
        got = current_resp();
        if (!rst_n_i) begin
            prev_req_fire = 1'b0;
            prev_flush    = 1'b0;
            prev_hold     = 1'b0;
        end else begin
            // register is full after an accept or a stall, unless flushed
            exp_valid = !prev_flush && (prev_req_fire || prev_hold);
            exp_ready = !exp_valid || resp_ready_i;
            assert (resp_valid_o === exp_valid) else begin
                proto_errors++;
                $display("error: resp_valid_o expected %h actual %h",
                         exp_valid, resp_valid_o);
            end
            assert (req_ready_o === exp_ready) else begin
                proto_errors++;
                $display("error: req_ready_o expected %h actual %h",
                         exp_ready, req_ready_o);
            end
            if (prev_hold) begin
                compare_resp(held, got);
            end
            if (flush_i) begin
                exp_q.delete();
                model_fcc = fcc_commit_i;
            end else begin
                if (exp_valid && resp_ready_i) begin
                    compare_resp(exp_q.pop_front(), got);
                end
                if (req_valid_i && exp_ready) begin
                    exp_q.push_back(predict_response());
                end
            end
            prev_req_fire = req_valid_i && exp_ready;
            prev_flush    = flush_i;
            prev_hold     = exp_valid && !resp_ready_i && !flush_i;
            held          = got;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // mix of special encodings and random bits
    function automatic logic [fp_width-1:0] rand_fp();
        logic [31:0] r;
        logic [7:0]  e;
        r = $urandom();
        e = 8'($urandom_range(254, 1));
        case ($urandom_range(7, 0))
            0: return {r[31], 31'h0};
            1: return {r[31], 8'hff, 23'h0};
            2: return {r[31], 8'hff, 1'b0, r[21:0] | 22'h1};
            3: return {r[31], 8'hff, 1'b1, r[21:0]};
            4: return {r[31], 8'h00, r[22:0] | 23'h1};
            7: return r;
            default: return {r[31], e, r[22:0]};
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        resp_ready_i = ($urandom_range(3, 0) != 0);
    endtask

    // sel picks the strobe, 7 sets fcmp and movxr2cf together
    task automatic issue_op(input int sel);
        logic accepted;
        {op_fcmp_i, op_movxr2cf_i, op_movcf2xr_i, op_bceqz_i} = '0;
        {op_bcnez_i, op_fsel_i, op_fclass_i} = '0;
        case (sel)
            0: op_fcmp_i = 1'b1;
            1: op_movxr2cf_i = 1'b1;
            2: op_movcf2xr_i = 1'b1;
            3: op_bceqz_i = 1'b1;
            4: op_bcnez_i = 1'b1;
            5: op_fsel_i = 1'b1;
            6: op_fclass_i = 1'b1;
            default: {op_fcmp_i, op_movxr2cf_i} = 2'b11;
        endcase
        cond_i   = $urandom();
        opa_i    = rand_fp();
        opb_i    = rand_fp();
        // equal and sign-flipped pairs hit eq and signed zeros
        case ($urandom_range(7, 0))
            0: opb_i = opa_i;
            1: opb_i = {~opa_i[31], opa_i[30:0]};
            default: ;
        endcase
        pc_i        = $urandom();
        offset_i    = $urandom();
        wid_i       = wid_i + 1'b1;
        req_valid_i = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready_o;
            step();
        end
        req_valid_i = 1'b0;
    endtask

    // drops the pending response and reloads fcc
    task automatic flush_pipe();
        flush_i      = 1'b1;
        fcc_commit_i = $urandom();
        resp_ready_i = 1'b0;
        step();
        flush_i = 1'b0;
    endtask

    initial begin
        void'($urandom(50149));
        {rst_n_i, flush_i, fcc_commit_i, req_valid_i, resp_ready_i} = '0;
        {op_fcmp_i, op_movxr2cf_i, op_movcf2xr_i, op_bceqz_i} = '0;
        {op_bcnez_i, op_fsel_i, op_fclass_i} = '0;
        {cond_i, opa_i, opb_i, pc_i, offset_i, wid_i} = '0;
        model_fcc    = 1'b0;
        value_errors = 0;
        proto_errors = 0;
        cycles       = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        assert (!resp_valid_o && req_ready_o) else begin
            proto_errors++;
            $display("error: unit is not empty after reset");
        end
        step();
        for (int n = 0; n < num_reqs; n++) begin
            if (n > 0 && $urandom_range(39, 0) == 0) begin
                flush_pipe();
                issue_op(2);
            end else begin
                issue_op($urandom_range(9, 0) % 8);
            end
            if ($urandom_range(15, 0) == 0) begin
                step();
            end
        end
        resp_ready_i = 1'b1;
        while (exp_q.size() != 0 || resp_valid_o) begin
            @(posedge clk);
            #1;
        end
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/wired_fcc_pkg.sv
source/fp32_classifier.sv
source/fp32_compare.sv
source/fcc_exec.sv
source/wired_fcc_top.sv
test/tb_wired_fcc.sv
